//--- rtl/dram_pkg.sv
package dram_pkg;

    localparam int DQ_WIDTH   = 16;             // x16 data pins
    localparam int DM_WIDTH   = DQ_WIDTH / 8;   // One mask pin per byte lane
    localparam int ADDR_WIDTH = 17;
    localparam int BA_WIDTH   = 2;              // Single bank group
    localparam int NUM_BANKS  = 1 << BA_WIDTH;
    localparam int BURST_LEN  = 8;              // Fixed BL8

    // Command pins shared with the address bus while act_n is high
    localparam int RAS_BIT = 16;
    localparam int CAS_BIT = 15;
    localparam int WE_BIT  = 14;

    typedef logic [DQ_WIDTH-1:0] dq_t;
    typedef logic [DM_WIDTH-1:0] dm_t;  // Bit set blocks its byte
    typedef logic [BA_WIDTH-1:0] bank_t;

    // Refresh pattern is not modelled and falls into NOP
    typedef enum logic [2:0] {
        NOP,
        ACT,
        PRE,
        RD,
        WR
    } cmd_e;

    typedef enum logic [1:0] {
        IDLE,
        ACTIVATING,
        ACTIVE,
        PRECHARGING
    } bank_state_e;

endpackage

//--- rtl/dram_ifs.sv
`timescale 1ns/1ps

// Decoder to bank machines, plus state coming back
interface bank_ctrl_if #(
    parameter int ROW_BITS = 4
);
    import dram_pkg::*;

    logic [NUM_BANKS-1:0] act_req;              // One-hot activate strobe
    logic [NUM_BANKS-1:0] pre_req;              // One-hot precharge strobe
    logic [ROW_BITS-1:0]  act_row;              // Row for the activate
    bank_state_e          state    [NUM_BANKS]; // Each bank drives its own entry
    logic [ROW_BITS-1:0]  open_row [NUM_BANKS];

    modport decoder (
        output act_req,
        output pre_req,
        output act_row,
        input  state,
        input  open_row
    );

    modport bank (
        input  act_req,
        input  pre_req,
        input  act_row,
        output state,
        output open_row
    );
endinterface

// Accepted RD/WR handed to the burst engine
interface col_req_if #(
    parameter int ROW_BITS = 4,
    parameter int COL_BITS = 4
);
    import dram_pkg::*;

    logic                req;       // Single-cycle pulse
    logic                is_write;
    bank_t               bank;
    logic [ROW_BITS-1:0] row;       // Open row of that bank
    logic [COL_BITS-1:0] col;       // Starting column of the burst

    modport source (output req, is_write, bank, row, col);
    modport sink   (input  req, is_write, bank, row, col);
endinterface

//--- rtl/latency_timer.sv
`timescale 1ns/1ps

module latency_timer (
    input  logic       clk_in,
    input  logic       rst_n,
    input  logic       load,       // Restart the count
    input  logic [7:0] load_value,
    output logic       done        // Level, high while count is zero
);

    logic [7:0] count_q;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;  // Same as an expired count
        end else if (load) begin
            count_q <= load_value;
        end else if (count_q != '0) begin
            count_q <= count_q - 8'd1;  // Stops at zero
        end
    end

    assign done = (count_q == '0);

endmodule

//--- rtl/bank_fsm.sv
`timescale 1ns/1ps

module bank_fsm #(
    parameter int BANK_IDX    = 0,
    parameter int ACT_LATENCY = 6,  // Must be at least 2
    parameter int PRE_LATENCY = 4,  // Must be at least 2
    parameter int ROW_BITS    = 4
) (
    input  logic           clk_in,
    input  logic           rst_n,
    bank_ctrl_if.bank      bk
);
    import dram_pkg::*;

    // Strobe is seen at the command edge t, so the timer covers the edges
    // in between and the state flips at t+LAT-1; a command sampled at t+LAT
    // then finds the new state
    localparam logic [7:0] ACT_LOAD = 8'(ACT_LATENCY - 2);
    localparam logic [7:0] PRE_LOAD = 8'(PRE_LATENCY - 2);

    bank_state_e         state_q;
    logic [ROW_BITS-1:0] row_q;
    logic                act_hit;
    logic                pre_hit;
    logic                tmr_load;
    logic [7:0]          tmr_value;
    logic                tmr_done;

    // Strobes arrive only for legal commands
    assign act_hit   = bk.act_req[BANK_IDX];
    assign pre_hit   = bk.pre_req[BANK_IDX];
    assign tmr_load  = act_hit || pre_hit;
    assign tmr_value = act_hit ? ACT_LOAD : PRE_LOAD;

    latency_timer u_latency_timer (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .load       (tmr_load),
        .load_value (tmr_value),
        .done       (tmr_done)
    );

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:        if (act_hit)  state_q <= ACTIVATING;
                ACTIVATING:  if (tmr_done) state_q <= ACTIVE;       // Row now open
                ACTIVE:      if (pre_hit)  state_q <= PRECHARGING;
                PRECHARGING: if (tmr_done) state_q <= IDLE;
                default:                   state_q <= IDLE;
            endcase
        end
    end

    // Open row latched with the activate
    always_ff @(posedge clk_in) begin
        if (act_hit) begin
            row_q <= bk.act_row;
        end
    end

    assign bk.state[BANK_IDX]    = state_q;
    assign bk.open_row[BANK_IDX] = row_q;

endmodule

//--- rtl/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder #(
    parameter int ROW_BITS = 4,
    parameter int COL_BITS = 4
) (
    input  logic                             clk_in,
    input  logic                             rst_n,
    input  logic                             cs_n,
    input  logic                             act_n,
    input  logic [dram_pkg::ADDR_WIDTH-1:0]  addr,
    input  dram_pkg::bank_t                  ba,
    output logic                             cmd_error,
    bank_ctrl_if.decoder                     bk,
    col_req_if.source                        col
);
    import dram_pkg::*;

    cmd_e        cmd;
    bank_state_e cur_state;
    logic        col_ready;   // Spacing since last RD/WR satisfied
    logic        legal;
    logic        col_accept;

    // Pin pattern to command
    always_comb begin
        cmd = NOP;
        if (!cs_n) begin
            if (!act_n) begin
                cmd = ACT;
            end else begin
                case ({addr[RAS_BIT], addr[CAS_BIT], addr[WE_BIT]})
                    3'b010:  cmd = PRE;
                    3'b101:  cmd = RD;
                    3'b100:  cmd = WR;
                    default: cmd = NOP;  // Refresh and unused codes
                endcase
            end
        end
    end

    assign cur_state = bk.state[ba];

    always_comb begin
        case (cmd)
            ACT:     legal = (cur_state == IDLE);
            PRE:     legal = (cur_state == ACTIVE);
            RD, WR:  legal = (cur_state == ACTIVE) && col_ready;
            default: legal = 1'b1;  // NOP never errors
        endcase
    end

    assign col_accept = ((cmd == RD) || (cmd == WR)) && legal;

    // Strobes go out in the command cycle, bank machines sample at the same edge
    assign bk.act_req = (cmd == ACT && legal) ? (NUM_BANKS'(1) << ba) : '0;
    assign bk.pre_req = (cmd == PRE && legal) ? (NUM_BANKS'(1) << ba) : '0;
    assign bk.act_row = addr[ROW_BITS-1:0];

    assign col.req      = col_accept;
    assign col.is_write = (cmd == WR);
    assign col.bank     = ba;
    assign col.row      = bk.open_row[ba];
    assign col.col      = addr[COL_BITS-1:0];

    // Next accepted column command no earlier than BURST_LEN edges later
    latency_timer u_col_timer (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .load       (col_accept),
        .load_value (8'(BURST_LEN - 1)),
        .done       (col_ready)
    );

    // One-cycle pulse after the offending edge
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            cmd_error <= 1'b0;
        end else begin
            cmd_error <= (cmd != NOP) && !legal;
        end
    end

endmodule

//--- rtl/dram_array.sv
`timescale 1ns/1ps

module dram_array #(
    parameter int DATA_WIDTH = 16,
    parameter int BANK_BITS  = 2,
    parameter int ROW_BITS   = 4,
    parameter int COL_BITS   = 4
) (
    input  logic                                   clk_in,
    input  logic                                   wr_en,
    input  logic [BANK_BITS+ROW_BITS+COL_BITS-1:0] wr_addr,  // {bank, row, col}
    input  logic [DATA_WIDTH-1:0]                  wr_data,
    input  logic [DATA_WIDTH/8-1:0]                wr_mask,  // 1 keeps old byte
    input  logic [BANK_BITS+ROW_BITS+COL_BITS-1:0] rd_addr,
    output logic [DATA_WIDTH-1:0]                  rd_data
);

    localparam int DEPTH = 1 << (BANK_BITS + ROW_BITS + COL_BITS);
    localparam int LANES = DATA_WIDTH / 8;

    logic [DATA_WIDTH-1:0] mem [DEPTH];  // One word per {bank, row, col}

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            for (int b = 0; b < LANES; b++) begin
                if (!wr_mask[b]) begin
                    mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    assign rd_data = mem[rd_addr];  // Asynchronous read

endmodule

//--- rtl/burst_engine.sv
`timescale 1ns/1ps

module burst_engine #(
    parameter int CAS_LATENCY = 12,  // At least 1
    parameter int ROW_BITS    = 4,
    parameter int COL_BITS    = 4
) (
    input  logic            clk_in,
    input  logic            rst_n,
    col_req_if.sink         col,
    input  dram_pkg::dq_t   dq_in,
    input  dram_pkg::dm_t   dm_in,
    output dram_pkg::dq_t   dq_out,
    output logic            dq_valid   // High on read beats
);
    import dram_pkg::*;

    localparam int BEAT_BITS = $clog2(BURST_LEN);
    localparam int MEM_ADDR  = BA_WIDTH + ROW_BITS + COL_BITS;

    typedef struct packed {
        bank_t               bank;
        logic [ROW_BITS-1:0] row;
        logic [COL_BITS-1:0] col;
    } col_ent_t;

    // Offset walks within the aligned group of BURST_LEN columns
    function automatic logic [COL_BITS-1:0] wrap_col(
        input logic [COL_BITS-1:0]  base,
        input logic [BEAT_BITS-1:0] beat
    );
        return (base & ~COL_BITS'(BURST_LEN - 1)) |
               ((base + COL_BITS'(beat)) & COL_BITS'(BURST_LEN - 1));
    endfunction

    col_ent_t             req_ent;
    logic                 wr_start;
    logic                 wr_active;
    logic [BEAT_BITS-1:0] wr_beat;
    col_ent_t             wr_ent;
    logic                 mem_wr_en;
    logic [MEM_ADDR-1:0]  mem_wr_addr;

    logic                 dl_valid [CAS_LATENCY];  // Read latency line
    col_ent_t             dl_ent   [CAS_LATENCY];
    logic                 rd_start;
    logic                 rd_active;
    logic [BEAT_BITS-1:0] rd_beat;
    col_ent_t             rd_ent;
    logic [MEM_ADDR-1:0]  mem_rd_addr;
    dq_t                  mem_rd_data;

    assign req_ent  = '{bank: col.bank, row: col.row, col: col.col};
    assign wr_start = col.req && col.is_write;

    // Write beats, beat 0 goes in with the request
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            wr_active <= 1'b0;
            wr_beat   <= '0;
        end else if (wr_start) begin
            wr_active <= 1'b1;
            wr_beat   <= BEAT_BITS'(1);
        end else if (wr_active) begin
            wr_beat <= wr_beat + 1'b1;
            if (wr_beat == BEAT_BITS'(BURST_LEN - 1)) begin
                wr_active <= 1'b0;  // Last beat taken this edge
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (wr_start) begin
            wr_ent <= req_ent;
        end
    end

    assign mem_wr_en   = wr_start || wr_active;
    assign mem_wr_addr = wr_start ?
        {req_ent.bank, req_ent.row, wrap_col(req_ent.col, '0)} :
        {wr_ent.bank, wr_ent.row, wrap_col(wr_ent.col, wr_beat)};

    // Reads wait CAS_LATENCY edges, several can be in flight
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < CAS_LATENCY; i++) begin
                dl_valid[i] <= 1'b0;
            end
        end else begin
            dl_valid[0] <= col.req && !col.is_write;
            for (int i = 1; i < CAS_LATENCY; i++) begin
                dl_valid[i] <= dl_valid[i-1];
            end
        end
    end

    always_ff @(posedge clk_in) begin
        dl_ent[0] <= req_ent;
        for (int i = 1; i < CAS_LATENCY; i++) begin
            dl_ent[i] <= dl_ent[i-1];
        end
    end

    // Entry leaving the line gives beat 0 at edge t+CAS_LATENCY
    assign rd_start = dl_valid[CAS_LATENCY-1];

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            rd_active <= 1'b0;
            rd_beat   <= '0;
            dq_valid  <= 1'b0;
        end else begin
            dq_valid <= rd_start || rd_active;
            if (rd_start) begin
                rd_active <= 1'b1;  // Back-to-back read takes over here
                rd_beat   <= BEAT_BITS'(1);
            end else if (rd_active) begin
                rd_beat <= rd_beat + 1'b1;
                if (rd_beat == BEAT_BITS'(BURST_LEN - 1)) begin
                    rd_active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rd_start) begin
            rd_ent <= dl_ent[CAS_LATENCY-1];
        end
        if (rd_start || rd_active) begin
            dq_out <= mem_rd_data;  // Sees every write beat before this edge
        end
    end

    assign mem_rd_addr = rd_start ?
        {dl_ent[CAS_LATENCY-1].bank, dl_ent[CAS_LATENCY-1].row,
         wrap_col(dl_ent[CAS_LATENCY-1].col, '0)} :
        {rd_ent.bank, rd_ent.row, wrap_col(rd_ent.col, rd_beat)};

    dram_array #(
        .DATA_WIDTH (DQ_WIDTH),
        .BANK_BITS  (BA_WIDTH),
        .ROW_BITS   (ROW_BITS),
        .COL_BITS   (COL_BITS)
    ) u_dram_array (
        .clk_in  (clk_in),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (dq_in),
        .wr_mask (dm_in),
        .rd_addr (mem_rd_addr),
        .rd_data (mem_rd_data)
    );

endmodule

//--- rtl/ddr4_x16_device.sv
`timescale 1ns/1ps

module ddr4_x16_device #(
    parameter int CAS_LATENCY = 12,
    parameter int ACT_LATENCY = 6,
    parameter int PRE_LATENCY = 4,
    parameter int ROW_BITS    = 4,
    parameter int COL_BITS    = 4   // At least 3 for the burst group
) (
    input  logic                            clk_in,
    input  logic                            rst_n,
    input  logic                            cs_n,
    input  logic                            act_n,
    input  logic [dram_pkg::ADDR_WIDTH-1:0] addr,   // ras/cas/we on top bits
    input  dram_pkg::bank_t                 ba,
    input  dram_pkg::dq_t                   dq_in,
    input  dram_pkg::dm_t                   dm_in,
    output dram_pkg::dq_t                   dq_out,
    output logic                            dq_valid,
    output logic                            cmd_error
);
    import dram_pkg::*;

    bank_ctrl_if #(.ROW_BITS(ROW_BITS)) u_bank_ctrl_if ();
    col_req_if #(.ROW_BITS(ROW_BITS), .COL_BITS(COL_BITS)) u_col_req_if ();

    cmd_decoder #(
        .ROW_BITS (ROW_BITS),
        .COL_BITS (COL_BITS)
    ) u_cmd_decoder (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .cs_n      (cs_n),
        .act_n     (act_n),
        .addr      (addr),
        .ba        (ba),
        .cmd_error (cmd_error),
        .bk        (u_bank_ctrl_if.decoder),
        .col       (u_col_req_if.source)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        bank_fsm #(
            .BANK_IDX    (b),
            .ACT_LATENCY (ACT_LATENCY),
            .PRE_LATENCY (PRE_LATENCY),
            .ROW_BITS    (ROW_BITS)
        ) u_bank_fsm (
            .clk_in (clk_in),
            .rst_n  (rst_n),
            .bk     (u_bank_ctrl_if.bank)
        );
    end

    burst_engine #(
        .CAS_LATENCY (CAS_LATENCY),
        .ROW_BITS    (ROW_BITS),
        .COL_BITS    (COL_BITS)
    ) u_burst_engine (
        .clk_in   (clk_in),
        .rst_n    (rst_n),
        .col      (u_col_req_if.sink),
        .dq_in    (dq_in),
        .dm_in    (dm_in),
        .dq_out   (dq_out),
        .dq_valid (dq_valid)
    );

endmodule

//--- test/ddr4_x16_device_asserts.sv
`timescale 1ns/1ps

module ddr4_x16_device_asserts #(
    parameter int ACT_LATENCY = 6
) (
    input logic                  clk_in,
    input logic                  rst_n,
    input logic                  dq_valid,
    input dram_pkg::bank_state_e state
);
    import dram_pkg::*;

    int valid_run;   // Length of the current dq_valid run
    int act_cycles;  // Samples spent in ACTIVATING

    always @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            valid_run  <= 0;
            act_cycles <= 0;
        end else begin
            valid_run  <= dq_valid ? valid_run + 1 : 0;
            act_cycles <= (state == ACTIVATING) ? act_cycles + 1 : 0;
        end
    end

    a_valid_after_reset: assert property (@(posedge clk_in) $rose(rst_n) |-> !dq_valid)
        else $error("dq_valid high right after reset");

    a_valid_runs: assert property (@(posedge clk_in) disable iff (!rst_n)
        $fell(dq_valid) |-> (valid_run % BURST_LEN) == 0)
        else $error("dq_valid run of %0d cycles", valid_run);

    // Command edge counts as the first of ACT_LATENCY, so ACT_LATENCY-1 samples here
    a_act_time: assert property (@(posedge clk_in) disable iff (!rst_n)
        (state == ACTIVE && $past(state) == ACTIVATING) |-> act_cycles == ACT_LATENCY - 1)
        else $error("Bank became active after %0d activating cycles", act_cycles);

endmodule

bind burst_engine ddr4_x16_device_asserts u_burst_asserts (
    .clk_in   (clk_in),
    .rst_n    (rst_n),
    .dq_valid (dq_valid),
    .state    (dram_pkg::IDLE)   // No bank state inside the burst engine
);

bind bank_fsm ddr4_x16_device_asserts #(.ACT_LATENCY(ACT_LATENCY)) u_bank_asserts (
    .clk_in   (clk_in),
    .rst_n    (rst_n),
    .dq_valid (1'b0),            // Banks carry no read data
    .state    (state_q)
);

//--- test/tb_ddr4_x16_device.sv
`timescale 1ns/1ps

module tb_ddr4_x16_device;
    import dram_pkg::*;

    localparam int CAS_LATENCY = 12;
    localparam int ACT_LATENCY = 6;
    localparam int PRE_LATENCY = 4;
    localparam int ROW_BITS    = 4;
    localparam int COL_BITS    = 4;
    localparam int WORDS       = 1 << (BA_WIDTH + ROW_BITS + COL_BITS);

    logic                  clk_in = 1'b0;
    logic                  rst_n;
    logic                  cs_n;
    logic                  act_n;
    logic [ADDR_WIDTH-1:0] addr;
    bank_t                 ba;
    dq_t                   dq_in;
    dm_t                   dm_in;
    dq_t                   dq_out;
    logic                  dq_valid;
    logic                  cmd_error;

    logic [31:0]         lfsr = 32'heb11_a08e;
    string               test_name = "reset";
    int                  value_errors = 0;
    int                  timeout_errors = 0;

    // Reference model state
    int                  cyc;                  // Edge number since reset
    bank_state_e         m_state [NUM_BANKS];
    int                  m_ready [NUM_BANKS];  // Edge where the pending transition lands
    logic [ROW_BITS-1:0] m_row   [NUM_BANKS];
    int                  m_last_col;           // Edge of last accepted RD/WR
    dq_t                 m_data  [WORDS];
    dq_t                 m_known [WORDS];      // Bits of bytes written at least once
    int                  wr_base;
    int                  wr_beat;
    int                  wr_left;
    int                  rdq_start [$];        // First output edge of each read
    int                  rdq_base  [$];        // {bank, row, col} word index
    logic                exp_valid;
    logic                exp_err;
    dq_t                 exp_dq;
    dq_t                 exp_care;

    always #4 clk_in = ~clk_in;  // 8 ns period

    ddr4_x16_device #(
        .CAS_LATENCY (CAS_LATENCY),
        .ACT_LATENCY (ACT_LATENCY),
        .PRE_LATENCY (PRE_LATENCY),
        .ROW_BITS    (ROW_BITS),
        .COL_BITS    (COL_BITS)
    ) u_ddr4_x16_device (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .cs_n      (cs_n),
        .act_n     (act_n),
        .addr      (addr),
        .ba        (ba),
        .dq_in     (dq_in),
        .dm_in     (dm_in),
        .dq_out    (dq_out),
        .dq_valid  (dq_valid),
        .cmd_error (cmd_error)
    );

    // Galois LFSR x^32+x^22+x^2+x+1 stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return val;
    endfunction

    // Word of beat k with the column wrapping inside its aligned group of eight
    function automatic int beat_addr(input int base, input int k);
        return (base & ~7) | ((base + k) & 7);
    endfunction

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error [%s] %s: expected %0b, actual %0b", test_name, what, exp, act);
        end
    endtask

    task automatic check_dq(input string what, input dq_t exp, input dq_t act, input dq_t care);
        if ((act & care) !== (exp & care)) begin
            value_errors++;
            $display("** Error [%s] %s: expected %h, actual %h (known bits %h)",
                     test_name, what, exp, act, care);
        end
    endtask

    always @(posedge clk_in) begin : ref_model
        cmd_e cmd;
        int   k;
        int   a;
        if (!rst_n) begin
            cyc        = 0;
            m_last_col = -BURST_LEN;  // First column command is free
            wr_left    = 0;
            exp_valid  = 1'b0;
            exp_err    = 1'b0;
            rdq_start.delete();
            rdq_base.delete();
            for (int b = 0; b < NUM_BANKS; b++) begin
                m_state[b] = IDLE;
            end
        end else begin
            cyc++;
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (m_state[b] == ACTIVATING && cyc >= m_ready[b]) m_state[b] = ACTIVE;
                if (m_state[b] == PRECHARGING && cyc >= m_ready[b]) m_state[b] = IDLE;
            end
            // Beat shown after this edge sees writes up to the previous edge
            exp_valid = 1'b0;
            if (rdq_start.size() > 0 && cyc >= rdq_start[0]) begin
                k         = cyc - rdq_start[0];
                a         = beat_addr(rdq_base[0], k);
                exp_valid = 1'b1;
                exp_dq    = m_data[a];
                exp_care  = m_known[a];
                if (k == BURST_LEN - 1) begin
                    void'(rdq_start.pop_front());
                    void'(rdq_base.pop_front());
                end
            end
            cmd = NOP;
            if (!cs_n && !act_n) begin
                cmd = ACT;
            end else if (!cs_n) begin
                case (addr[16:14])  // ras, cas, we
                    3'b010:  cmd = PRE;
                    3'b101:  cmd = RD;
                    3'b100:  cmd = WR;
                    default: cmd = NOP;
                endcase
            end
            exp_err = 1'b0;
            case (cmd)
                ACT: begin
                    if (m_state[ba] == IDLE) begin
                        m_state[ba] = ACTIVATING;
                        m_ready[ba] = cyc + ACT_LATENCY;
                        m_row[ba]   = addr[ROW_BITS-1:0];
                    end else begin
                        exp_err = 1'b1;
                    end
                end
                PRE: begin
                    if (m_state[ba] == ACTIVE) begin
                        m_state[ba] = PRECHARGING;
                        m_ready[ba] = cyc + PRE_LATENCY;
                    end else begin
                        exp_err = 1'b1;
                    end
                end
                RD, WR: begin
                    if (m_state[ba] == ACTIVE && cyc - m_last_col >= BURST_LEN) begin
                        m_last_col = cyc;
                        a = {ba, m_row[ba], addr[COL_BITS-1:0]};
                        if (cmd == RD) begin
                            rdq_start.push_back(cyc + CAS_LATENCY);
                            rdq_base.push_back(a);
                        end else begin
                            wr_base = a;
                            wr_beat = 0;
                            wr_left = BURST_LEN;
                        end
                    end else begin
                        exp_err = 1'b1;
                    end
                end
                default: ;
            endcase
            if (wr_left > 0) begin  // Beat 0 comes with the command
                a = beat_addr(wr_base, wr_beat);
                for (int l = 0; l < DM_WIDTH; l++) begin
                    if (!dm_in[l]) begin
                        m_data[a][l*8 +: 8]  = dq_in[l*8 +: 8];
                        m_known[a][l*8 +: 8] = 8'hff;
                    end
                end
                wr_beat++;
                wr_left--;
            end
        end
    end

    // Outputs compared mid-cycle
    always @(negedge clk_in) begin
        if (rst_n) begin
            check_flag("dq_valid", exp_valid, dq_valid);
            check_flag("cmd_error", exp_err, cmd_error);
            if (exp_valid) check_dq("dq_out", exp_dq, dq_out, exp_care);
        end
    end

    task automatic drive_pins(input logic cs, input logic an, input logic [ADDR_WIDTH-1:0] a,
                              input bank_t b);
        @(posedge clk_in);
        cs_n  <= cs;
        act_n <= an;
        addr  <= a;
        ba    <= b;
        dq_in <= dq_t'(rand_bits(DQ_WIDTH));  // Fresh data every beat
        dm_in <= dm_t'(rand_bits(DM_WIDTH) & rand_bits(DM_WIDTH));  // Mostly open lanes
    endtask

    task automatic nop_cycles(input int n);
        repeat (n) drive_pins(1'b1, 1'b1, '0, '0);
    endtask

    task automatic cmd_act(input bank_t b, input int row);
        drive_pins(1'b0, 1'b0, ADDR_WIDTH'(row), b);
    endtask

    task automatic cmd_pre(input bank_t b);
        drive_pins(1'b0, 1'b1, {3'b010, 14'h0}, b);
    endtask

    // RD or WR followed by pad NOP cycles
    task automatic cmd_col(input logic is_wr, input bank_t b, input int col, input int pad);
        drive_pins(1'b0, 1'b1, {2'b10, !is_wr, 14'(col)}, b);
        nop_cycles(pad);
    endtask

    task automatic open_bank(input bank_t b, input int row);
        cmd_act(b, row);
        nop_cycles(ACT_LATENCY - 1);  // Next command lands on edge t+ACT_LATENCY
    endtask

    task automatic close_bank(input bank_t b);
        cmd_pre(b);
        nop_cycles(PRE_LATENCY - 1);
    endtask

    task automatic wait_reads_done(input int limit);
        int n;
        n = 0;
        nop_cycles(1);  // Last command is sampled before the loop looks
        do begin
            @(negedge clk_in);
            n++;
        end while ((rdq_start.size() != 0 || dq_valid) && n < limit);
        if (rdq_start.size() != 0 || dq_valid) begin
            timeout_errors++;
            $display("Timeout in %s: read bursts still pending after %0d cycles",
                     test_name, limit);
        end
    endtask

    initial begin
        int    cols [6];
        int    wcol [NUM_BANKS];
        int    op;
        bank_t b;
        int    c;
        rst_n = 1'b0;
        cs_n  = 1'b1;
        act_n = 1'b1;
        addr  = '0;
        ba    = '0;
        dq_in = '0;
        dm_in = '0;
        for (int i = 0; i < WORDS; i++) begin
            m_known[i] = '0;
        end
        repeat (16) @(posedge clk_in);
        rst_n <= 1'b1;
        nop_cycles(2);

        test_name = "masked_write_readback";
        open_bank(0, 5);
        for (int i = 0; i < 6; i++) begin
            cols[i] = rand_bits(COL_BITS);
            cmd_col(1'b1, 0, cols[i], BURST_LEN - 1);
        end
        for (int i = 0; i < 6; i++) begin
            cmd_col(1'b0, 0, cols[i], BURST_LEN - 1);
        end
        wait_reads_done(64);

        test_name = "read_latency";  // dq_valid edges checked every cycle
        cmd_col(1'b0, 0, cols[0], 0);
        wait_reads_done(64);

        test_name = "pipelined_reads";
        wcol[0] = cols[0];
        for (int i = 1; i < NUM_BANKS; i++) begin
            open_bank(bank_t'(i), rand_bits(ROW_BITS));
        end
        for (int i = 1; i < NUM_BANKS; i++) begin
            wcol[i] = rand_bits(COL_BITS);
            cmd_col(1'b1, bank_t'(i), wcol[i], BURST_LEN - 1);
        end
        for (int i = 0; i < 8; i++) begin
            cmd_col(1'b0, bank_t'(i % NUM_BANKS), wcol[i % NUM_BANKS], BURST_LEN - 1);
        end
        wait_reads_done(64);

        test_name = "illegal_commands";
        close_bank(3);
        cmd_col(1'b0, 3, 0, 1);              // Read to idle bank
        cmd_pre(3);                          // Precharge to idle bank
        nop_cycles(1);
        cmd_act(0, 9);                       // Activate to open bank
        nop_cycles(1);
        cmd_act(3, 2);
        nop_cycles(ACT_LATENCY - 2);
        cmd_col(1'b0, 3, 0, 0);              // One cycle early
        cmd_col(1'b0, 3, 0, 2);              // Exactly ACT_LATENCY, accepted
        cmd_col(1'b1, 0, cols[1], 4);        // Three cycles after the read
        cmd_col(1'b0, 0, cols[1], BURST_LEN - 1);  // Old data must remain
        wait_reads_done(64);

        test_name = "row_switch";
        cmd_pre(0);
        nop_cycles(1);
        cmd_act(0, 11);                      // Still precharging
        nop_cycles(PRE_LATENCY);
        open_bank(0, 11);
        c = rand_bits(COL_BITS);
        cmd_col(1'b1, 0, c, BURST_LEN - 1);
        cmd_col(1'b0, 0, c, BURST_LEN - 1);
        close_bank(0);
        open_bank(0, 5);
        for (int i = 0; i < 6; i++) begin
            cmd_col(1'b0, 0, cols[i], BURST_LEN - 1);
        end
        wait_reads_done(128);

        test_name = "random_stream";
        for (int i = 0; i < 400; i++) begin
            op = rand_bits(3);
            b  = bank_t'(rand_bits(BA_WIDTH));
            case (op)
                0:       cmd_act(b, rand_bits(2));  // Few rows for more reuse
                1:       cmd_pre(b);
                2, 3:    cmd_col(1'b0, b, rand_bits(COL_BITS), 0);
                4, 5:    cmd_col(1'b1, b, rand_bits(COL_BITS), 0);
                6:       drive_pins(1'b0, 1'b1, {3'b001, 14'h0}, b);  // Refresh code
                default: ;
            endcase
            nop_cycles(rand_bits(3));
        end
        wait_reads_done(128);

        $display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- ddr4_x16_device.f
rtl/dram_pkg.sv
rtl/dram_ifs.sv
rtl/latency_timer.sv
rtl/bank_fsm.sv
rtl/cmd_decoder.sv
rtl/dram_array.sv
rtl/burst_engine.sv
rtl/ddr4_x16_device.sv
test/ddr4_x16_device_asserts.sv
test/tb_ddr4_x16_device.sv
